// File: ecg_pkg.sv
`default_nettype none

package ecg_pkg;

  // block word, read from the msb down
  localparam int SUFFIX_BITS = 128;

  // group layout
  localparam int NUM_GROUPS = 4;
  localparam int SAMPLES_PER_GROUP = 4;
  localparam int NUM_COEFFS = NUM_GROUPS * SAMPLES_PER_GROUP;

  localparam int COEFF_BITS = 9;

  // worst case 1 + 4 * (5 + 1 + 20) + 16 = 121 bits
  localparam int MAX_SAMPLE_BITS = 5;

  // holds a sample width from 0 to MAX_SAMPLE_BITS
  localparam int WIDTH_BITS = $clog2(MAX_SAMPLE_BITS + 1);

  localparam int SIZE_BITS = 8;

  typedef logic [SUFFIX_BITS-1:0] suffix_t;

  typedef logic signed [COEFF_BITS-1:0] coeff_t;

  typedef logic [SIZE_BITS-1:0] size_t;

endpackage

`default_nettype wire

// File: ecg_group_parser.sv
`default_nettype none

module ecg_group_parser
  import ecg_pkg::*;
(
  input  wire suffix_t                 window,
  output logic [WIDTH_BITS-1:0]        width,
  output logic [SAMPLES_PER_GROUP-1:0]
               [MAX_SAMPLE_BITS-1:0]   mags,
  output size_t                        used_bits
);

  suffix_t payload;

  // unary prefix, stops at the first zero or at MAX_SAMPLE_BITS ones
  always_comb begin
    width = '0;
    for (int i = 0; i < MAX_SAMPLE_BITS; i++) begin
      if ((width == WIDTH_BITS'(i)) && window[SUFFIX_BITS-1-i]) begin
        width = width + 1'b1;
      end
    end
  end

  // skip the ones and the terminating zero
  assign payload = window << (width + 1'b1);

  for (genvar k = 0; k < SAMPLES_PER_GROUP; k++) begin : g_mag
    suffix_t aligned;

    assign aligned = payload << (k * width);

    // top MAX_SAMPLE_BITS, right-justified to w bits
    assign mags[k] = aligned[SUFFIX_BITS-1 -: MAX_SAMPLE_BITS] >> (MAX_SAMPLE_BITS - width);
  end

  // prefix is w+1 bits, then four w-bit fields
  assign used_bits = size_t'(width) * size_t'(SAMPLES_PER_GROUP + 1) + 8'd1;

endmodule

`default_nettype wire

// File: ecg_block_input.sv
`default_nettype none

module ecg_block_input
  import ecg_pkg::*;
#(
  parameter int SSM_IDX = 0
) (
  input  wire          clk,
  input  wire          rst_n,
  input  wire          in_valid,
  input  wire suffix_t in_suffix,
  input  wire          fifo_pop,
  output logic         blk_valid,
  output suffix_t      blk_suffix,
  output logic         blk_skip,
  output logic         in_credit
);

  logic    skip_bit;
  suffix_t stripped;

  // component-skip flag only exists for substreams above 1
  assign skip_bit = (SSM_IDX > 1) ? in_suffix[SUFFIX_BITS-1] : 1'b0;
  assign stripped = (SSM_IDX > 1) ? (in_suffix << 1) : in_suffix;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      blk_valid <= 1'b0;
      in_credit <= 1'b0;
    end else begin
      blk_valid <= in_valid;
      // one credit back per set leaving the output fifo
      in_credit <= fifo_pop;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      blk_suffix <= stripped;
      blk_skip   <= skip_bit;
    end
  end

endmodule

`default_nettype wire

// File: ecg_block_decoder.sv
`default_nettype none

module ecg_block_decoder
  import ecg_pkg::*;
#(
  parameter int SSM_IDX = 0
) (
  input  wire          clk,
  input  wire          rst_n,
  input  wire          blk_valid,
  input  wire suffix_t blk_suffix,
  input  wire          blk_skip,
  output logic         dec_valid,
  output coeff_t       dec_coeffs [NUM_COEFFS],
  output size_t        dec_size
);

  // the skip flag costs one bit whenever it is present
  localparam size_t SKIP_BITS = (SSM_IDX > 1) ? 8'd1 : 8'd0;

  suffix_t                                          stream [NUM_GROUPS+1];
  logic    [WIDTH_BITS-1:0]                         width  [NUM_GROUPS];
  logic    [SAMPLES_PER_GROUP-1:0][MAX_SAMPLE_BITS-1:0] mags [NUM_GROUPS];
  size_t                                            used   [NUM_GROUPS];

  suffix_t sign_stream;
  size_t   sign_cnt;
  size_t   group_bits;
  coeff_t  mag_ext;
  coeff_t  coeffs [NUM_COEFFS];
  size_t   size_d;

  assign stream[0] = blk_suffix;

  // each group starts where the previous one ended
  for (genvar g = 0; g < NUM_GROUPS; g++) begin : g_group
    ecg_group_parser u_parser (
      .window    (stream[g]),
      .width     (width[g]),
      .mags      (mags[g]),
      .used_bits (used[g])
    );

    assign stream[g+1] = stream[g] << used[g];
  end

  // sign bits follow group 3, one per nonzero magnitude
  always_comb begin
    sign_stream = stream[NUM_GROUPS];
    sign_cnt    = '0;
    group_bits  = '0;
    mag_ext     = '0;
    for (int g = 0; g < NUM_GROUPS; g++) begin
      group_bits = group_bits + used[g];
      for (int s = 0; s < SAMPLES_PER_GROUP; s++) begin
        coeffs[g*SAMPLES_PER_GROUP+s] = '0;
        if (!blk_skip && (width[g] != '0) && (mags[g][s] != '0)) begin
          mag_ext = {{(COEFF_BITS-MAX_SAMPLE_BITS){1'b0}}, mags[g][s]};
          coeffs[g*SAMPLES_PER_GROUP+s] = sign_stream[SUFFIX_BITS-1] ? -mag_ext : mag_ext;
          sign_stream = sign_stream << 1;
          sign_cnt    = sign_cnt + 8'd1;
        end
      end
    end

    // a skipped component reads nothing past its flag
    if (blk_skip) begin
      size_d = 8'd1;
    end else begin
      size_d = SKIP_BITS + group_bits + sign_cnt;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= blk_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (blk_valid) begin
      dec_coeffs <= coeffs;
      dec_size   <= size_d;
    end
  end

endmodule

`default_nettype wire

// File: ecg_coeff_output.sv
`default_nettype none

module ecg_coeff_output
  import ecg_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input  wire         clk,
  input  wire         rst_n,
  input  wire         dec_valid,
  input  wire coeff_t dec_coeffs [NUM_COEFFS],
  input  wire size_t  dec_size,
  input  wire         out_credit,
  output logic        out_valid,
  output coeff_t      out_coeffs [NUM_COEFFS],
  output size_t       out_size,
  output logic        fifo_pop
);

  localparam int PTR_BITS    = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_BITS    = $clog2(FIFO_DEPTH + 1);
  localparam int CREDIT_BITS = 8;

  coeff_t mem_coeffs [FIFO_DEPTH][NUM_COEFFS];
  size_t  mem_size   [FIFO_DEPTH];

  logic [PTR_BITS-1:0]    wr_ptr;
  logic [PTR_BITS-1:0]    rd_ptr;
  logic [CNT_BITS-1:0]    fifo_count;
  logic [CREDIT_BITS-1:0] credit_cnt;

  // release the head only with an entry and a downstream credit
  assign fifo_pop   = (fifo_count != '0) && (credit_cnt != '0);
  assign out_valid  = fifo_pop;
  assign out_coeffs = mem_coeffs[rd_ptr];
  assign out_size   = mem_size[rd_ptr];

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      mem_coeffs[wr_ptr] <= dec_coeffs;
      mem_size[wr_ptr]   <= dec_size;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fifo_count <= '0;
      credit_cnt <= '0;
    end else begin
      if (dec_valid) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (fifo_pop) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end

      case ({dec_valid, fifo_pop})
        2'b10:   fifo_count <= fifo_count + 1'b1;
        2'b01:   fifo_count <= fifo_count - 1'b1;
        default: fifo_count <= fifo_count;
      endcase

      // credit in and pop together leave the count unchanged
      case ({out_credit, fifo_pop})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: ecg_decoder_top.sv
`default_nettype none

module ecg_decoder_top
  import ecg_pkg::*;
#(
  parameter int SSM_IDX    = 0,
  parameter int FIFO_DEPTH = 4
) (
  input  wire          clk,
  input  wire          rst_n,
  input  wire          in_valid,
  input  wire suffix_t in_suffix,
  output logic         in_credit,
  input  wire          out_credit,
  output logic         out_valid,
  output coeff_t       out_coeffs [NUM_COEFFS],
  output size_t        out_size
);

  logic    blk_valid;
  suffix_t blk_suffix;
  logic    blk_skip;
  logic    dec_valid;
  coeff_t  dec_coeffs [NUM_COEFFS];
  size_t   dec_size;
  logic    fifo_pop;

  ecg_block_input #(
    .SSM_IDX (SSM_IDX)
  ) u_block_input (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_suffix  (in_suffix),
    .fifo_pop   (fifo_pop),
    .blk_valid  (blk_valid),
    .blk_suffix (blk_suffix),
    .blk_skip   (blk_skip),
    .in_credit  (in_credit)
  );

  ecg_block_decoder #(
    .SSM_IDX (SSM_IDX)
  ) u_block_decoder (
    .clk        (clk),
    .rst_n      (rst_n),
    .blk_valid  (blk_valid),
    .blk_suffix (blk_suffix),
    .blk_skip   (blk_skip),
    .dec_valid  (dec_valid),
    .dec_coeffs (dec_coeffs),
    .dec_size   (dec_size)
  );

  ecg_coeff_output #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_coeff_output (
    .clk        (clk),
    .rst_n      (rst_n),
    .dec_valid  (dec_valid),
    .dec_coeffs (dec_coeffs),
    .dec_size   (dec_size),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_coeffs (out_coeffs),
    .out_size   (out_size),
    .fifo_pop   (fifo_pop)
  );

endmodule

`default_nettype wire

// File: ecg_assertions.sv
`default_nettype none

module ecg_credit_assertions #(
  parameter int FIFO_DEPTH = 4
) (
  input wire                               clk,
  input wire                               rst_n,
  input wire                               in_valid,
  input wire                               in_credit,
  input wire                               out_credit,
  input wire                               out_valid,
  input wire [$clog2(FIFO_DEPTH+1)-1:0]    fifo_count
);

  // upstream credit as the rules allow it
  int up_credits;
  // downstream credits granted and not yet spent
  int down_credits;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      up_credits   <= FIFO_DEPTH;
      down_credits <= 0;
    end else begin
      up_credits   <= up_credits + (in_credit ? 1 : 0) - (in_valid ? 1 : 0);
      down_credits <= down_credits + (out_credit ? 1 : 0) - (out_valid ? 1 : 0);
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> (down_credits > 0))
    else $error("out_valid with no downstream credit");

  // a credit returned this cycle may be spent at once
  assert property (@(posedge clk) disable iff (!rst_n)
    in_valid |-> ((up_credits + (in_credit ? 1 : 0)) > 0))
    else $error("block sent without upstream credit");

  assert property (@(posedge clk) disable iff (!rst_n) int'(fifo_count) <= FIFO_DEPTH)
    else $error("output FIFO overflow");

endmodule

bind ecg_decoder_top ecg_credit_assertions #(
  .FIFO_DEPTH (FIFO_DEPTH)
) credit_checks (
  .clk        (clk),
  .rst_n      (rst_n),
  .in_valid   (in_valid),
  .in_credit  (in_credit),
  .out_credit (out_credit),
  .out_valid  (out_valid),
  .fifo_count (u_coeff_output.fifo_count)
);

`default_nettype wire

// File: tb_ecg_decoder.sv
`default_nettype none

module tb_ecg_decoder;
  import ecg_pkg::*;

  localparam int SSM_IDX        = 2;
  localparam int FIFO_DEPTH     = 4;
  localparam int NUM_PATTERNS   = 12;
  // suffix, sixteen coefficients, size
  localparam int WORDS_PER_LINE = NUM_COEFFS + 2;
  localparam int HOLD_CYCLES    = 40;
  localparam int TIMEOUT_CYCLES = NUM_PATTERNS * 40 + 200;

  logic    clk;
  logic    rst_n;
  logic    in_valid;
  suffix_t in_suffix;
  logic    in_credit;
  logic    out_credit;
  logic    out_valid;
  coeff_t  out_coeffs [NUM_COEFFS];
  size_t   out_size;

  logic [127:0] pat_mem [NUM_PATTERNS*WORDS_PER_LINE];

  int   seed;
  int   error_count;
  int   sent_count;
  int   rx_count;
  int   up_credits;
  int   gap;
  int   base;
  logic hold_active;
  logic popped_last;

  ecg_decoder_top #(
    .SSM_IDX    (SSM_IDX),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) ecg_decoder_top_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_suffix  (in_suffix),
    .in_credit  (in_credit),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_coeffs (out_coeffs),
    .out_size   (out_size)
  );

  always #20 clk = ~clk;

  task automatic check_value(input logic [127:0] got, input logic [127:0] expected,
                             input string what);
    if (got !== expected) begin
      error_count = error_count + 1;
      $display("mismatch at %0t: %s got %0h expected %0h", $time, what, got, expected);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic report_failure(input string what);
    error_count = error_count + 1;
    $display("error at %0t: %s", $time, what);
    $display("sim failed");
    $fatal(1);
  endtask

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    in_suffix   = '0;
    out_credit  = 1'b0;
    hold_active = 1'b1;
    popped_last = 1'b0;
    seed        = 32'heb9a_4171;
    error_count = 0;
    sent_count  = 0;
    rx_count    = 0;
    up_credits  = FIFO_DEPTH;
    $readmemh("ecg_patterns.txt", pat_mem);
    repeat (8) @(posedge clk);
    #2 rst_n = 1'b1;
    wait (rx_count == NUM_PATTERNS);
    repeat (4) @(posedge clk);
    if (error_count == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      $display("sim failed");
      $fatal(1);
    end
  end

  // upstream sender, one block per cycle while it holds credit
  initial begin
    wait (rst_n == 1'b1);
    while (sent_count < NUM_PATTERNS) begin
      @(posedge clk);
      #1;
      if (in_credit) begin
        up_credits = up_credits + 1;
      end
      #1;
      if (up_credits > 0) begin
        in_valid   = 1'b1;
        in_suffix  = pat_mem[sent_count*WORDS_PER_LINE];
        up_credits = up_credits - 1;
        sent_count = sent_count + 1;
      end else begin
        in_valid = 1'b0;
      end
    end
    @(posedge clk);
    #2 in_valid = 1'b0;
  end

  // downstream receiver, long stall first and then random gaps
  initial begin
    wait (rst_n == 1'b1);
    repeat (HOLD_CYCLES) @(posedge clk);
    #2;
    hold_active = 1'b0;
    if (sent_count != FIFO_DEPTH) begin
      report_failure("upstream did not stall after using all of its credits");
    end
    for (int i = 0; i < NUM_PATTERNS; i++) begin
      out_credit = 1'b1;
      @(posedge clk);
      #2 out_credit = 1'b0;
      gap = $random(seed) & 3;
      repeat (gap) begin
        @(posedge clk);
        #2;
      end
    end
  end

  // results must come out in pattern order
  initial begin
    wait (rst_n == 1'b1);
    while (rx_count < NUM_PATTERNS) begin
      @(posedge clk);
      #1;
      // a credit comes back one cycle after each result leaves
      check_value({127'd0, in_credit}, {127'd0, popped_last},
                  "in_credit one cycle after a result left");
      popped_last = out_valid;
      if (hold_active && out_valid) begin
        report_failure("out_valid rose while the downstream held back all credits");
      end
      if (out_valid) begin
        base = rx_count * WORDS_PER_LINE;
        for (int i = 0; i < NUM_COEFFS; i++) begin
          check_value({119'd0, out_coeffs[i]}, {119'd0, pat_mem[base+1+i][8:0]},
                      $sformatf("pattern %0d coefficient %0d", rx_count, i));
        end
        check_value({120'd0, out_size}, {120'd0, pat_mem[base+NUM_COEFFS+1][7:0]},
                    $sformatf("pattern %0d size", rx_count));
        rx_count = rx_count + 1;
      end
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    report_failure("timeout, the decoder stopped delivering results");
  end

endmodule

`default_nettype wire

// File: ecg_patterns.txt
// suffix word (128-bit hex), coefficients 0 to 15 (9-bit two's complement), size
// substream index 2, so the top bit of each suffix is the skip flag
80000000000000000000000000000000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 01
00000000000000000000000000000000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 05
56200000000000000000000000000000 1ff 000 001 001 000 000 000 000 000 000 000 000 000 000 000 000 0d
7df0441b25c28f4c0000000000000000 1e1 000 011 000 1fd 000 002 001 000 000 000 000 000 1fb 000 1f9 3e
5f7df7aaaa8000000000000000000000 001 1ff 001 1ff 001 1ff 001 1ff 001 1ff 001 1ff 001 1ff 001 1ff 29
ffffffffffffffffffffffffffffffff 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 01
0d068000000000000000000000000000 000 000 000 000 000 000 000 000 000 000 000 000 002 000 000 1fd 11
7df0441b25c28f4c0000000000000000 1e1 000 011 000 1fd 000 002 001 000 000 000 000 000 1fb 000 1f9 3e
56200000000000000000000000000000 1ff 000 001 001 000 000 000 000 000 000 000 000 000 000 000 000 0d
5f7df7aaaa8000000000000000000000 001 1ff 001 1ff 001 1ff 001 1ff 001 1ff 001 1ff 001 1ff 001 1ff 29
00000000000000000000000000000000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 05
0d068000000000000000000000000000 000 000 000 000 000 000 000 000 000 000 000 000 002 000 000 1fd 11

// File: compile.f
ecg_pkg.sv
ecg_group_parser.sv
ecg_block_input.sv
ecg_block_decoder.sv
ecg_coeff_output.sv
ecg_decoder_top.sv
ecg_assertions.sv
tb_ecg_decoder.sv

// File: run_sim.sh
#!/bin/sh
# build and run the decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_ecg_decoder -f compile.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
  exit 0
fi
exit 1
